// ==== all.f ====
+incdir+source
source/dram_pkg.sv
source/dram_request_port.sv
source/request_fifo.sv
source/command_sequencer.sv
source/signal_gen.sv
source/dram_cmd_top.sv
tb/dram_cmd_assertions.sv
tb/dram_cmd_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f all.f --top-module dram_cmd_tb -o dram_cmd_sim \
    && ./obj_dir/dram_cmd_sim | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null \
    && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== source/command_sequencer.sv ====
`timescale 1ns/100ps
`include "dram_macros.svh"

module command_sequencer
    import dram_pkg::*;
(
    input  logic       CLK,
    input  logic       reset,
    input  logic       empty,
    input  dram_req_t  head,
    output logic       pop,
    output seq_state_t state,
    output seq_state_t nstate,
    output dram_req_t  cur_req,
    output logic       ref_all,
    output logic       init_done
);

    logic [15:0] hold_cnt;
    logic [15:0] ref_cnt;
    logic        ref_due;
    seq_state_t  ret_state;

    // command that follows once the gap after s has run out
    function automatic seq_state_t follow_up(input seq_state_t s, input logic wr,
                                             input logic ref_pre);
        seq_state_t nxt;
        case (s)
            LOAD_MODE_DLL: nxt = LOAD_BG0_REG3;
            LOAD_BG0_REG3: nxt = LOAD_BG1_REG6;
            LOAD_BG1_REG6: nxt = LOAD_BG1_REG5;
            LOAD_BG1_REG5: nxt = LOAD_BG1_REG4;
            LOAD_BG1_REG4: nxt = LOAD_BG0_REG2;
            LOAD_BG0_REG2: nxt = LOAD_BG0_REG1;
            LOAD_BG0_REG1: nxt = LOAD_BG0_REG0;
            LOAD_BG0_REG0: nxt = ZQ_CL;
            ACTIVATE:      nxt = wr ? WRITE : READ;
            READ:          nxt = PRECHARGE;
            WRITE:         nxt = PRECHARGE;
            PRECHARGE:     nxt = ref_pre ? REFRESH : IDLE;
            default:       nxt = IDLE;
        endcase
        return nxt;
    endfunction

    always_comb begin
        nstate = state;
        pop    = 1'b0;
        case (state)
            POWER_UP: begin
                if (hold_cnt == 16'(`POWER_UP_CYCLES - 1))
                    nstate = PRE_RESET;
            end
            PRE_RESET: nstate = RESET;
            RESET: begin
                if (hold_cnt == 16'(`RESET_CYCLES - 1))
                    nstate = LOAD_MODE_DLL;
            end
            NOP: begin
                if (hold_cnt == 16'(`CMD_GAP - 1))
                    nstate = ret_state;
            end
            IDLE: begin
                // refresh wins, and is only looked at here
                if (ref_due) begin
                    nstate = PRECHARGE;
                end else if (!empty) begin
                    pop    = 1'b1;
                    nstate = ACTIVATE;
                end
            end
            // every command state lasts a single cycle
            default: nstate = NOP;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state     <= POWER_UP;
            hold_cnt  <= '0;
            ret_state <= IDLE;
            ref_all   <= 1'b0;
            init_done <= 1'b0;
        end else begin
            state    <= nstate;
            hold_cnt <= (nstate != state) ? '0 : hold_cnt + 1'b1;
            if (state != NOP && nstate == NOP)
                ret_state <= follow_up(state, cur_req.write, ref_all);
            if (state == IDLE && nstate != IDLE)
                ref_all <= ref_due;
            if (nstate == IDLE)
                init_done <= 1'b1;
        end
    end

    // refresh interval timer, runs once init is done
    always_ff @(posedge CLK) begin
        if (reset) begin
            ref_cnt <= '0;
            ref_due <= 1'b0;
        end else begin
            if (state == IDLE && ref_due)
                ref_due <= 1'b0;
            if (!init_done) begin
                ref_cnt <= '0;
            end else if (ref_cnt == 16'(`REFRESH_INTERVAL - 1)) begin
                ref_cnt <= '0;
                ref_due <= 1'b1;
            end else begin
                ref_cnt <= ref_cnt + 1'b1;
            end
        end
    end

    // request being served
    always_ff @(posedge CLK) begin
        if (pop)
            cur_req <= head;
    end

endmodule

// ==== source/dram_cmd_top.sv ====
`timescale 1ns/100ps

module dram_cmd_top
    import dram_pkg::*;
(
    input  logic       CLK,
    input  logic       reset,
    input  logic       req,
    input  dram_req_t  req_data,
    output logic       ack,
    output dram_pins_t pins,
    output logic       init_done
);

    logic       push;
    dram_req_t  push_data;
    logic       full;
    logic       empty;
    dram_req_t  head;
    logic       pop;
    seq_state_t state;
    seq_state_t nstate;
    dram_req_t  cur_req;
    logic       ref_all;

    dram_request_port i_dram_request_port (
        .CLK       (CLK),
        .reset     (reset),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .full      (full),
        .push      (push),
        .push_data (push_data)
    );

    request_fifo i_request_fifo (
        .CLK       (CLK),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pop       (pop),
        .empty     (empty),
        .head      (head)
    );

    command_sequencer i_command_sequencer (
        .CLK       (CLK),
        .reset     (reset),
        .empty     (empty),
        .head      (head),
        .pop       (pop),
        .state     (state),
        .nstate    (nstate),
        .cur_req   (cur_req),
        .ref_all   (ref_all),
        .init_done (init_done)
    );

    signal_gen i_signal_gen (
        .CLK       (CLK),
        .reset     (reset),
        .state     (state),
        .nstate    (nstate),
        .cur_req   (cur_req),
        .ref_all   (ref_all),
        .pins      (pins)
    );

endmodule

// ==== source/dram_macros.svh ====
`ifndef DRAM_MACROS_SVH
`define DRAM_MACROS_SVH

// request buffer entries
`define FIFO_DEPTH 4

// init holds, in clock cycles
`define POWER_UP_CYCLES 10
`define RESET_CYCLES 12

// NOP cycles after every issued command, at least one
`define CMD_GAP 3

// cycles between refresh requests, counted from init done
`define REFRESH_INTERVAL 400

`endif

// ==== source/dram_pkg.sv ====
package dram_pkg;

    // field widths
    parameter int RANK_BITS       = 1;
    parameter int BANK_GROUP_BITS = 2;
    parameter int BANK_BITS       = 2;
    parameter int ADDR_BITS       = 14;
    parameter int ROW_BITS        = 17;
    parameter int COL_BITS        = 10;

    typedef enum logic [4:0] {
        POWER_UP,
        PRE_RESET,
        RESET,
        NOP,
        LOAD_MODE_DLL,
        LOAD_BG0_REG3,
        LOAD_BG1_REG6,
        LOAD_BG1_REG5,
        LOAD_BG1_REG4,
        LOAD_BG0_REG2,
        LOAD_BG0_REG1,
        LOAD_BG0_REG0,
        ZQ_CL,
        IDLE,
        ACTIVATE,
        READ,
        WRITE,
        PRECHARGE,
        REFRESH
    } seq_state_t;

    // bit order is cs_n, act_n, ras_n, cas_n, we_n
    typedef enum logic [4:0] {
        DESEL_CMD     = 5'b11111,
        POWER_UP_PRG  = 5'b10000,
        LOAD_MODE_CMD = 5'b01000,
        REFRESH_CMD   = 5'b01001,
        PRECHARGE_CMD = 5'b01010,
        WRITE_CMD     = 5'b01100,
        READ_CMD      = 5'b01101,
        ZQ_CMD        = 5'b01110
    } cmd_t;

    // with act_n low the ras/cas/we pins carry row bits 16..14
    typedef union packed {
        cmd_t cmd;
        struct packed {
            logic       cs_n;
            logic       act_n;
            logic [2:0] row_hi;
        } act;
    } dram_cmd_u;

    typedef struct packed {
        logic                       write;
        logic [BANK_GROUP_BITS-1:0] bg;
        logic [BANK_BITS-1:0]       ba;
        logic [ROW_BITS-1:0]        row;
        logic [COL_BITS-1:0]        col;
    } dram_req_t;

    typedef struct packed {
        dram_cmd_u                  cmd;
        logic                       cke;
        logic                       reset_n;
        logic                       pwr;
        logic                       vref_ca;
        logic                       vref_dq;
        logic [RANK_BITS-1:0]       c;
        logic [BANK_GROUP_BITS-1:0] bg;
        logic [BANK_BITS-1:0]       ba;
        logic [ADDR_BITS-1:0]       addr;
        logic                       addr_17;
    } dram_pins_t;

endpackage

// ==== source/dram_request_port.sv ====
`timescale 1ns/100ps

module dram_request_port
    import dram_pkg::*;
(
    input  logic      CLK,
    input  logic      reset,
    input  logic      req,
    input  dram_req_t req_data,
    output logic      ack,
    input  logic      full,
    output logic      push,
    output dram_req_t push_data
);

    typedef enum logic {
        WAIT_REQ,
        WAIT_DROP
    } port_state_t;

    port_state_t port_state;
    port_state_t port_nstate;

    always_comb begin
        port_nstate = port_state;
        push        = 1'b0;
        case (port_state)
            WAIT_REQ: begin
                // hold off while the buffer has no room
                if (req && !full) begin
                    push        = 1'b1;
                    port_nstate = WAIT_DROP;
                end
            end
            WAIT_DROP: begin
                if (!req)
                    port_nstate = WAIT_REQ;
            end
            default: port_nstate = WAIT_REQ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset)
            port_state <= WAIT_REQ;
        else
            port_state <= port_nstate;
    end

    // ack is high for the whole time after the push until req drops
    assign ack       = (port_state == WAIT_DROP);
    assign push_data = req_data;

endmodule

// ==== source/request_fifo.sv ====
`timescale 1ns/100ps
`include "dram_macros.svh"

module request_fifo
    import dram_pkg::*;
(
    input  logic      CLK,
    input  logic      reset,
    input  logic      push,
    input  dram_req_t push_data,
    output logic      full,
    input  logic      pop,
    output logic      empty,
    output dram_req_t head
);

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    dram_req_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    // fall-through read
    assign head  = mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // simultaneous push and pop leaves count alone
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

// ==== source/signal_gen.sv ====
`timescale 1ns/100ps

module signal_gen
    import dram_pkg::*;
(
    input  logic       CLK,
    input  logic       reset,
    input  seq_state_t state,
    input  seq_state_t nstate,
    input  dram_req_t  cur_req,
    input  logic       ref_all,
    output dram_pins_t pins
);

    dram_cmd_u cmd_word;
    logic      issue;

    // a command state drives its pins only in the cycle it is left
    assign issue = (state != nstate);

    always_comb begin
        cmd_word.cmd = DESEL_CMD;
        pins.cke     = 1'b1;
        pins.reset_n = 1'b1;
        pins.pwr     = 1'b1;
        pins.vref_ca = 1'b1;
        pins.vref_dq = 1'b1;
        pins.c       = '0;
        pins.bg      = '0;
        pins.ba      = '0;
        pins.addr    = '0;
        pins.addr_17 = 1'b0;

        case (state)
            POWER_UP: begin
                cmd_word.cmd = POWER_UP_PRG;
                pins.cke     = 1'b0;
                pins.reset_n = 1'b0;
                pins.pwr     = 1'b0;
                pins.vref_ca = 1'b0;
                pins.vref_dq = 1'b0;
            end
            PRE_RESET: begin
                // supplies up, device still held in reset
                cmd_word.cmd = POWER_UP_PRG;
                pins.cke     = 1'b0;
                pins.reset_n = 1'b0;
            end
            RESET: begin
                cmd_word.cmd = POWER_UP_PRG;
                pins.cke     = 1'b0;
            end
            LOAD_MODE_DLL, LOAD_BG0_REG3, LOAD_BG1_REG6, LOAD_BG1_REG5,
            LOAD_BG1_REG4, LOAD_BG0_REG2, LOAD_BG0_REG1, LOAD_BG0_REG0: begin
                if (issue)
                    cmd_word.cmd = LOAD_MODE_CMD;
                // mode register select and value
                case (state)
                    LOAD_MODE_DLL: {pins.bg, pins.ba, pins.addr} = {2'h0, 2'h1, 14'h0001};
                    LOAD_BG0_REG3: {pins.bg, pins.ba, pins.addr} = {2'h0, 2'h3, 14'h0000};
                    LOAD_BG1_REG6: {pins.bg, pins.ba, pins.addr} = {2'h1, 2'h2, 14'h080F};
                    LOAD_BG1_REG5: {pins.bg, pins.ba, pins.addr} = {2'h1, 2'h1, 14'h0800};
                    LOAD_BG1_REG4: {pins.bg, pins.ba, pins.addr} = {2'h1, 2'h0, 14'h1000};
                    LOAD_BG0_REG2: {pins.bg, pins.ba, pins.addr} = {2'h0, 2'h2, 14'h0088};
                    LOAD_BG0_REG1: {pins.bg, pins.ba, pins.addr} = {2'h0, 2'h1, 14'h0001};
                    default:       {pins.bg, pins.ba, pins.addr} = {2'h0, 2'h0, 14'h041D};
                endcase
                if (!issue)
                    {pins.bg, pins.ba, pins.addr} = '0;
            end
            ZQ_CL: begin
                if (issue) begin
                    cmd_word.cmd = ZQ_CMD;
                    // A10 high selects long calibration
                    pins.addr    = 14'h0400;
                end
            end
            ACTIVATE: begin
                if (issue) begin
                    cmd_word.act.cs_n   = 1'b0;
                    cmd_word.act.act_n  = 1'b0;
                    cmd_word.act.row_hi = cur_req.row[16:14];
                    pins.bg             = cur_req.bg;
                    pins.ba             = cur_req.ba;
                    pins.addr           = cur_req.row[13:0];
                end
            end
            READ, WRITE: begin
                if (issue) begin
                    cmd_word.cmd = (state == WRITE) ? WRITE_CMD : READ_CMD;
                    pins.bg      = cur_req.bg;
                    pins.ba      = cur_req.ba;
                    // A12 set for BL8, A10 clear for no auto precharge
                    pins.addr    = {1'b0, 1'b1, 1'b0, 1'b0, cur_req.col};
                end
            end
            PRECHARGE: begin
                if (issue) begin
                    cmd_word.cmd  = PRECHARGE_CMD;
                    pins.bg       = ref_all ? '0 : cur_req.bg;
                    pins.ba       = ref_all ? '0 : cur_req.ba;
                    pins.addr[10] = ref_all;
                end
            end
            REFRESH: begin
                if (issue)
                    cmd_word.cmd = REFRESH_CMD;
            end
            default: cmd_word.cmd = DESEL_CMD;
        endcase

        pins.cmd = cmd_word;
    end

endmodule

// ==== tb/dram_cmd_assertions.sv ====
`timescale 1ns/100ps

module dram_cmd_assertions
    import dram_pkg::*;
(
    input logic       CLK,
    input logic       reset,
    input logic       req,
    input logic       ack,
    input dram_pins_t pins
);

    // ack only answers a pending request
    ack_rise_needs_req: assert property (@(posedge CLK) disable iff (reset)
        $rose(ack) |-> req)
        else $error("ack rose while req was low");

    // four-phase release, ack waits for req to fall
    ack_held_while_req: assert property (@(posedge CLK) disable iff (reset)
        (ack && req) |=> ack)
        else $error("ack dropped while req was still high");

    // no command may be selected with the clock disabled
    no_cmd_without_cke: assert property (@(posedge CLK) disable iff (reset)
        !pins.cke |-> pins.cmd.act.cs_n)
        else $error("chip select low while CKE low");

    reset_n_low_after_reset: assert property (@(posedge CLK)
        reset |=> !pins.reset_n)
        else $error("RESET_n not low in the first cycle after reset");

endmodule

bind dram_cmd_top dram_cmd_assertions i_dram_cmd_assertions (
    .CLK   (CLK),
    .reset (reset),
    .req   (req),
    .ack   (ack),
    .pins  (pins)
);

// ==== tb/dram_cmd_tb.sv ====
`timescale 1ns/100ps
`include "dram_macros.svh"

module dram_cmd_tb
    import dram_pkg::*;
();

    localparam int N_REQ    = 10;
    localparam int N_INIT   = 9;
    localparam int INIT_LEN = `POWER_UP_CYCLES + 1 + `RESET_CYCLES
                              + N_INIT * (`CMD_GAP + 1) + 1;

    // one command cycle as seen on the pins
    typedef struct packed {
        logic [4:0]  cmd;
        logic [1:0]  bg;
        logic [1:0]  ba;
        logic [13:0] addr;
    } cmd_rec_t;

    typedef struct packed {
        logic [8:0] pause;
        dram_req_t  rq;
    } entry_t;

    // pause, write, bank group, bank, row, column
    entry_t stim [N_REQ] = '{
        {9'd0,   1'b0, 2'd0, 2'd0, 17'h00000, 10'h000},
        {9'd0,   1'b1, 2'd1, 2'd2, 17'h1C3A5, 10'h3FF},
        {9'd0,   1'b0, 2'd3, 2'd1, 17'h14001, 10'h155},
        {9'd0,   1'b1, 2'd2, 2'd3, 17'h0BEEF, 10'h2AA},
        {9'd0,   1'b0, 2'd0, 2'd3, 17'h1FFFF, 10'h001},
        {9'd0,   1'b1, 2'd3, 2'd0, 17'h04000, 10'h200},
        // long pause so the refresh timer runs out while idle
        {9'd400, 1'b0, 2'd1, 2'd1, 17'h12345, 10'h0F0},
        {9'd0,   1'b1, 2'd2, 2'd2, 17'h08421, 10'h30C},
        {9'd0,   1'b0, 2'd1, 2'd0, 17'h1A5A5, 10'h111},
        {9'd0,   1'b1, 2'd3, 2'd3, 17'h15555, 10'h222}
    };

    // mode register loads in issue order, then long ZQ calibration
    cmd_rec_t init_cmds [N_INIT] = '{
        {LOAD_MODE_CMD, 2'h0, 2'h1, 14'h0001},
        {LOAD_MODE_CMD, 2'h0, 2'h3, 14'h0000},
        {LOAD_MODE_CMD, 2'h1, 2'h2, 14'h080F},
        {LOAD_MODE_CMD, 2'h1, 2'h1, 14'h0800},
        {LOAD_MODE_CMD, 2'h1, 2'h0, 14'h1000},
        {LOAD_MODE_CMD, 2'h0, 2'h2, 14'h0088},
        {LOAD_MODE_CMD, 2'h0, 2'h1, 14'h0001},
        {LOAD_MODE_CMD, 2'h0, 2'h0, 14'h041D},
        {ZQ_CMD,        2'h0, 2'h0, 14'h0400}
    };

    logic       CLK = 1'b0;
    logic       reset;
    logic       req;
    dram_req_t  req_data;
    logic       ack;
    dram_pins_t pins;
    logic       init_done;

    cmd_rec_t exp_q [$];
    int       cyc = 0;
    int       limit = 0;
    int       errors = 0;
    int       errs_at_open = 0;
    int       n_pass = 0;
    int       n_fail = 0;
    int       refreshes = 0;
    int       cmd_idx = 0;
    int       zq_cyc = 0;
    int       last_cyc = -1;
    logic     ref_pending = 1'b0;
    logic     init_seen = 1'b0;
    logic     saw_full = 1'b0;

    dram_cmd_top i_dram_cmd_top (
        .CLK       (CLK),
        .reset     (reset),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .pins      (pins),
        .init_done (init_done)
    );

    always #5 CLK = ~CLK;

    task automatic note_failure(input string what);
        $display("failure at cycle %0d: %s", cyc, what);
        errors++;
    endtask

    task automatic close_test(input string name);
        if (errors == errs_at_open) begin
            $display("%s: ok", name);
            n_pass++;
        end else begin
            $display("%s: %0d error(s)", name, errors - errs_at_open);
            n_fail++;
        end
        errs_at_open = errors;
    endtask

    // closed page sequence of activate, column access and single-bank precharge
    task automatic queue_request(input dram_req_t r);
        exp_q.push_back({2'b00, r.row[16:14], r.bg, r.ba, r.row[13:0]});
        // A12 set, A10 clear
        exp_q.push_back({r.write ? WRITE_CMD : READ_CMD, r.bg, r.ba, 4'b0100, r.col});
        exp_q.push_back({PRECHARGE_CMD, r.bg, r.ba, 14'h0000});
    endtask

    always @(posedge CLK) begin
        cyc <= cyc + 1;
        if (cyc > limit) begin
            $display("run did not finish within %0d cycles", limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // pin monitor
    always @(negedge CLK) begin
        cmd_rec_t   got;
        cmd_rec_t   want;
        logic       from_idle;
        int         idx;
        logic [6:0] ctl;
        if (!reset) begin
            if (req && i_dram_cmd_top.full)
                saw_full = 1'b1;
            if (init_done && !init_seen) begin
                init_seen = 1'b1;
                assert (cyc - zq_cyc == `CMD_GAP + 1)
                    else note_failure("init_done did not rise right after the ZQ gap");
                close_test("init sequence");
            end
            if (!pins.cmd.act.cs_n) begin
                got = {pins.cmd, pins.bg, pins.ba, pins.addr};
                // supplies up and single rank whenever a command goes out
                ctl = {pins.cke, pins.reset_n, pins.pwr, pins.vref_ca, pins.vref_dq,
                       pins.c, pins.addr_17};
                assert (ctl == 7'b1111100) else begin
                    $display("ERROR pins cke/reset_n/pwr/vref_ca/vref_dq/c/addr_17 got %h expected 7c",
                             ctl);
                    errors++;
                end
                // activate and precharge-all leave IDLE, which adds cycles
                from_idle = !pins.cmd.act.act_n
                    || (pins.cmd.cmd == PRECHARGE_CMD && pins.addr[10]);
                if (last_cyc >= 0 && from_idle) begin
                    assert (cyc - last_cyc - 1 >= `CMD_GAP)
                        else note_failure($sformatf("gap of %0d cycles", cyc - last_cyc - 1));
                end else if (last_cyc >= 0) begin
                    assert (cyc - last_cyc - 1 == `CMD_GAP)
                        else note_failure($sformatf("gap of %0d cycles", cyc - last_cyc - 1));
                end
                last_cyc = cyc;
                if (ref_pending) begin
                    assert (pins.cmd.cmd == REFRESH_CMD)
                        else note_failure("precharge-all was not followed by REFRESH");
                    ref_pending = 1'b0;
                    refreshes++;
                end else if (pins.cmd.cmd == PRECHARGE_CMD && pins.addr[10]) begin
                    assert (init_seen && cmd_idx >= N_INIT && (cmd_idx - N_INIT) % 3 == 0)
                        else note_failure("refresh precharge came inside a request group");
                    ref_pending = 1'b1;
                end else if (exp_q.size() == 0) begin
                    note_failure("command issued with none expected");
                end else begin
                    want = exp_q.pop_front();
                    assert (got == want) else begin
                        $display("ERROR pins cmd/bg/ba/addr got %h/%h/%h/%h expected %h/%h/%h/%h",
                                 got.cmd, got.bg, got.ba, got.addr,
                                 want.cmd, want.bg, want.ba, want.addr);
                        errors++;
                    end
                    cmd_idx++;
                    if (cmd_idx == N_INIT) begin
                        zq_cyc = cyc;
                    end else if (cmd_idx > N_INIT && (cmd_idx - N_INIT) % 3 == 0) begin
                        idx = (cmd_idx - N_INIT) / 3 - 1;
                        close_test($sformatf("request %0d %s", idx,
                                             stim[idx].rq.write ? "write" : "read"));
                    end
                end
            end
        end
    end

    // host driver
    initial begin
        int idle;
        int pause_sum;
        int base;
        void'($urandom(89034));
        reset    = 1'b1;
        req      = 1'b0;
        req_data = '0;
        pause_sum = 0;
        foreach (init_cmds[i])
            exp_q.push_back(init_cmds[i]);
        foreach (stim[i]) begin
            pause_sum += int'(stim[i].pause);
            queue_request(stim[i].rq);
        end
        base  = INIT_LEN + N_REQ * (3 * (`CMD_GAP + 1) + 8) + pause_sum;
        limit = base + (base / `REFRESH_INTERVAL + 1) * (2 * (`CMD_GAP + 1) + 1) + 100;

        repeat (2) @(posedge CLK);
        reset <= 1'b0;
        @(negedge CLK);
        assert (!pins.cke && !pins.reset_n && !pins.pwr) else begin
            $display("ERROR pins cke/reset_n/pwr got %h expected 0",
                     {pins.cke, pins.reset_n, pins.pwr});
            errors++;
        end

        for (int i = 0; i < N_REQ; i++) begin
            idle = int'(stim[i].pause) + int'($urandom % 4);
            repeat (idle) @(posedge CLK);
            @(posedge CLK);
            req      <= 1'b1;
            req_data <= stim[i].rq;
            do @(negedge CLK); while (!ack);
            @(posedge CLK);
            req <= 1'b0;
            do @(negedge CLK); while (ack);
        end

        while (exp_q.size() != 0 || ref_pending)
            @(negedge CLK);
        repeat (`CMD_GAP + 2) @(negedge CLK);
        assert (refreshes > 0) else note_failure("no refresh was seen during the run");
        assert (saw_full) else note_failure("the request FIFO never filled");
        $display("%0d tests passed, %0d failed, %0d refreshes, %0d errors",
                 n_pass, n_fail, refreshes, errors);
        if (errors == 0 && n_fail == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
